// ==== common/cpuPkg.sv ====
package cpuPkg;

    // Data and address width
    parameter int xlen = 32;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSlt = 4'd5, // Signed compare
        aluSll = 4'd6,
        aluSrl = 4'd7
    } aluOpT;

    // Decoded control for one instruction
    typedef struct packed {
        logic              regWrite;
        logic              aluSrc;    // Immediate as second operand
        logic              memWrite;
        logic              memToReg;  // Writeback from data memory
        logic              branch;
        aluOpT             aluOp;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
        logic [xlen-1:0]   imm;       // Sign-extended
        logic              illegal;
    } ctrlT;

    // One retired instruction as seen at the top level
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] inst;
        logic            rdWe;
        logic [4:0]      rd;
        logic [xlen-1:0] rdData;
        logic            memWe;
        logic [xlen-1:0] memAddr;
        logic [xlen-1:0] memData;
    } retireT;

endpackage

// ==== decode/instDecode.sv ====
`timescale 1ns/10ps

module instDecode
    import cpuPkg::*;
(
    input  logic [xlen-1:0] inst,
    output ctrlT            ctrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        ctrl     = '0;
        ctrl.rs1 = inst[19:15];
        ctrl.rs2 = inst[24:20];
        ctrl.rd  = inst[11:7];
        ctrl.imm = immI;

        case (opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluOp = funct7[5] ? aluSub : aluAdd; // bit 30 picks sub
                    3'b111: ctrl.aluOp = aluAnd;
                    3'b110: ctrl.aluOp = aluOr;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b010: ctrl.aluOp = aluSlt;
                    3'b001: ctrl.aluOp = aluSll;
                    3'b101: ctrl.aluOp = aluSrl;
                    default: ctrl.illegal = 1'b1;
                endcase
                // Only sub may set funct7 bit 30, sra is not supported
                if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    ctrl.illegal = 1'b1;
                end
            end
            opImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                case (funct3)
                    3'b000: ctrl.aluOp = aluAdd;
                    3'b111: ctrl.aluOp = aluAnd;
                    3'b110: ctrl.aluOp = aluOr;
                    3'b100: ctrl.aluOp = aluXor;
                    3'b010: ctrl.aluOp = aluSlt;
                    default: ctrl.illegal = 1'b1; // No immediate shifts
                endcase
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.illegal  = (funct3 != 3'b010); // lw only
            end
            opStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.imm      = immS;
                ctrl.illegal  = (funct3 != 3'b010);
            end
            opBranch: begin
                ctrl.branch  = 1'b1;
                ctrl.aluOp   = aluSub;  // Equal operands give zero
                ctrl.imm     = immB;
                ctrl.illegal = (funct3 != 3'b000);
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // Illegal words retire as no-ops
        if (ctrl.illegal) begin
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.memToReg = 1'b0;
            ctrl.branch   = 1'b0;
        end
    end

endmodule

// ==== dv/retireChecker.sv ====
`timescale 1ns/10ps

module retireChecker
    import cpuPkg::*;
#(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            run,
    input  logic            progWe,
    input  logic [xlen-1:0] progAddr,
    input  logic [xlen-1:0] progData,
    input  logic            retireValid,
    input  retireT          retire,
    output int              errCount,
    output int              retireCount
);

    logic [31:0] imem [imemWords];
    logic [31:0] dmem [dmemWords];
    logic [31:0] regs [32];   // regs[0] never written
    logic [31:0] modelPc;
    int          errs = 0;
    int          retires = 0;

    assign errCount    = errs;
    assign retireCount = retires;

    initial begin
        for (int i = 0; i < dmemWords; i++) begin
            dmem[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        modelPc = '0;
    end

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("ERR %s expected %h actual %h (pc %h)", name, expVal, actVal, modelPc);
            errs++;
        end
    endtask

    // Reference arithmetic for the R and I formats
    function automatic logic [31:0] computeAlu(input logic [2:0] f3, input logic isSub,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b111:  return a & b;
            3'b110:  return a | b;
            3'b100:  return a ^ b;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b001:  return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    // Outputs are settled at the falling edge
    always @(negedge CLK) begin : modelStep
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] memAddr;
        logic [31:0] nextPc;
        logic [4:0]  rd;
        logic        wr;
        logic        st;
        logic        expWe;
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            modelPc = '0;
            if (retireValid) begin
                $display("retireValid was high during reset");
                errs++;
            end
        end else begin
            if (progWe && !run) begin
                imem[(progAddr >> 2) % imemWords] = progData;
            end
            if (retireValid && !run) begin
                $display("retireValid was high while run was low");
                errs++;
            end else if (retireValid) begin
                inst    = imem[(modelPc >> 2) % imemWords];
                rd      = inst[11:7];
                a       = regs[inst[19:15]];
                b       = regs[inst[24:20]];
                res     = '0;
                memAddr = '0;
                wr      = 1'b0;
                st      = 1'b0;
                nextPc  = modelPc + 4;
                case (inst[6:0])
                    7'h33: begin
                        wr  = 1'b1;
                        res = computeAlu(inst[14:12], inst[30], a, b);
                    end
                    7'h13: begin
                        wr  = 1'b1;
                        res = computeAlu(inst[14:12], 1'b0, a, {{20{inst[31]}}, inst[31:20]});
                    end
                    7'h03: begin
                        wr  = 1'b1;
                        res = dmem[((a + {{20{inst[31]}}, inst[31:20]}) >> 2) % dmemWords];
                    end
                    7'h23: begin
                        st      = 1'b1;
                        memAddr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    end
                    7'h63: begin
                        if (a == b) begin
                            nextPc = modelPc + {{19{inst[31]}}, inst[31], inst[7],
                                                inst[30:25], inst[11:8], 1'b0};
                        end
                    end
                    default: begin
                        $display("Model fetched an unsupported opcode at pc %h", modelPc);
                        errs++;
                    end
                endcase
                expWe = wr && (rd != 5'd0); // x0 targets are not writes

                checkField("retire.pc", modelPc, retire.pc);
                checkField("retire.inst", inst, retire.inst);
                checkField("retire.rdWe", {31'b0, expWe}, {31'b0, retire.rdWe});
                checkField("retire.rd", expWe ? {27'b0, rd} : 32'h0, {27'b0, retire.rd});
                checkField("retire.rdData", expWe ? res : 32'h0, retire.rdData);
                checkField("retire.memWe", {31'b0, st}, {31'b0, retire.memWe});
                checkField("retire.memAddr", memAddr, retire.memAddr);
                checkField("retire.memData", st ? b : 32'h0, retire.memData);

                if (expWe) begin
                    regs[rd] = res;
                end
                if (st) begin
                    dmem[(memAddr >> 2) % dmemWords] = b;
                end
                modelPc = nextPc;
                retires++;
            end
        end
    end

endmodule

// ==== dv/tbSingleCpu.sv ====
`timescale 1ns/10ps

module tbSingleCpu
    import cpuPkg::*;
();

    localparam int imemWords  = 256;
    localparam int dmemWords  = 256;
    localparam int progLen    = 200;
    localparam int runTimeout = 4000; // Cycles allowed to reach the final loop
    localparam logic [31:0] finalPc = (progLen - 1) * 4;

    logic            CLK = 1'b0;
    logic            RST;
    logic            run;
    logic            progWe;
    logic [xlen-1:0] progAddr;
    logic [xlen-1:0] progData;
    logic            retireValid;
    retireT          retire;

    logic [31:0] lfsrState = 32'h8f8f;
    logic [31:0] prog [progLen];
    int          checkErrors;
    int          retireCount;
    int          tbErrors = 0;
    int          cycles;

    always #2 CLK = ~CLK;

    singleCpu #(.imemWords(imemWords), .dmemWords(dmemWords)) i_singleCpu (
        .CLK(CLK), .RST(RST), .run(run), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .retireValid(retireValid), .retire(retire)
    );

    retireChecker #(.imemWords(imemWords), .dmemWords(dmemWords)) u_retireChecker (
        .CLK(CLK), .RST(RST), .run(run), .progWe(progWe), .progAddr(progAddr),
        .progData(progData), .retireValid(retireValid), .retire(retire),
        .errCount(checkErrors), .retireCount(retireCount)
    );

    // Galois form, polynomial x^32+x^22+x^2+x+1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]}; // One step per bit
        end
        return v;
    endfunction

    // Fields land in R-type positions, callers place immediate pieces
    function automatic logic [31:0] packInst(input logic [31:0] f7, input logic [31:0] rs2,
                                             input logic [31:0] rs1, input logic [31:0] f3,
                                             input logic [31:0] rd, input logic [31:0] opc);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    task automatic buildProgram();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] f3;
        logic [31:0] off;
        logic [31:0] k;
        logic [31:0] immF3 [5] = '{32'd0, 32'd7, 32'd6, 32'd4, 32'd2};
        logic [31:0] regF3 [7] = '{32'd0, 32'd7, 32'd6, 32'd4, 32'd2, 32'd1, 32'd5};
        for (int i = 0; i < progLen - 1; i++) begin
            kind = randBits(3);
            rd   = randBits(5);
            rs1  = randBits(5);
            rs2  = randBits(5);
            imm  = randBits(12);
            off  = randBits(4) << 2; // First 16 words of data memory
            if (kind <= 2) begin
                f3 = regF3[randBits(3) % 7]; // No sltu in the subset
                prog[i] = packInst((f3 == 0 && randBits(1) == 1) ? 32'h20 : 32'h0,
                                   rs2, rs1, f3, rd, 32'h33);
            end else if (kind <= 4) begin
                f3 = immF3[randBits(3) % 5];
                prog[i] = packInst(imm >> 5, imm, rs1, f3, rd, 32'h13);
            end else if (kind == 5) begin
                prog[i] = packInst(off >> 5, off, 32'h0, 32'h2, rd, 32'h03); // lw rd,off(x0)
            end else if (kind == 6) begin
                prog[i] = packInst(off >> 5, rs2, 32'h0, 32'h2, off, 32'h23);
            end else begin
                k = randBits(2) + 1;
                if (k > progLen - 1 - i) begin
                    k = progLen - 1 - i; // Never past the final loop
                end
                off = k * 4;
                if (randBits(1) == 1) begin
                    rs2 = rs1; // Forces a taken branch
                end
                prog[i] = packInst((((off >> 12) & 1) << 6) | ((off >> 5) & 63), rs2, rs1,
                                   32'h0, (((off >> 1) & 15) << 1) | ((off >> 11) & 1), 32'h63);
            end
        end
        prog[progLen - 1] = packInst(32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h63);
    endtask

    task automatic writeProgram();
        for (int i = 0; i < progLen; i++) begin
            progWe   = 1'b1;
            progAddr = i * 4;
            progData = prog[i];
            @(posedge CLK);
            #1;
        end
        progWe = 1'b0;
    endtask

    initial begin
        RST      = 1'b1;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        buildProgram();
        repeat (10) @(posedge CLK);
        #1 RST = 1'b0;
        writeProgram();
        @(posedge CLK);
        #1 run = 1'b1;

        cycles = 0;
        while (!(retireValid && retire.pc == finalPc) && cycles < runTimeout) begin
            @(negedge CLK);
            cycles++;
        end
        if (cycles >= runTimeout) begin
            $display("Timeout: pc did not reach the final loop within %0d cycles", runTimeout);
            tbErrors++;
        end

        repeat (6) @(posedge CLK); // Self-loop retires a few times
        #1 run = 1'b0;
        repeat (4) @(posedge CLK);
        if (retireCount == 0) begin
            $display("No instruction retired during the run");
            tbErrors++;
        end

        $display("Closing: %0d errors, %0d retires", tbErrors + checkErrors, retireCount);
        if (tbErrors + checkErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps

module alu
    import cpuPkg::*;
(
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOpT           op,
    output logic [xlen-1:0] result,
    output logic            zero
);

    logic [4:0] shamt;

    assign shamt = b[4:0]; // Shift amount from low five bits

    always_comb begin
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluXor: result = a ^ b;
            aluSlt: begin
                result = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            aluSll: result = a << shamt;
            aluSrl: result = a >> shamt;
            default: result = '0;
        endcase
    end

    // Used by beq through subtraction
    assign zero = (result == '0);

endmodule

// ==== hdl/dataMem.sv ====
`timescale 1ns/10ps

module dataMem
    import cpuPkg::*;
#(
    parameter int dmemWords = 256
) (
    input  logic            CLK,
    input  logic [xlen-1:0] addr,
    input  logic [xlen-1:0] wrData,
    input  logic            we,
    output logic [xlen-1:0] rdData
);

    localparam int addrBits = $clog2(dmemWords);

    logic [xlen-1:0] mem [dmemWords];
    logic [addrBits-1:0] wordIdx;

    // Contents start at zero and are kept across RST
    initial begin
        for (int i = 0; i < dmemWords; i++) begin
            mem[i] = '0;
        end
    end

    assign wordIdx = addr[addrBits+1:2]; // Low two bits ignored

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];

endmodule

// ==== hdl/instMem.sv ====
`timescale 1ns/10ps

module instMem
    import cpuPkg::*;
#(
    parameter int imemWords = 256
) (
    input  logic            CLK,
    input  logic            progWe,
    input  logic [xlen-1:0] progAddr,
    input  logic [xlen-1:0] progData,
    input  logic [xlen-1:0] pc,
    output logic [xlen-1:0] inst
);

    localparam int addrBits = $clog2(imemWords);

    logic [xlen-1:0] mem [imemWords];

    // Program load, one word per strobe
    always_ff @(posedge CLK) begin
        if (progWe) begin
            mem[progAddr[addrBits+1:2]] <= progData;
        end
    end

    // Zero-latency fetch, byte offset ignored
    assign inst = mem[pc[addrBits+1:2]];

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/10ps

module regFile
    import cpuPkg::*;
(
    input  logic            CLK,
    input  logic            RST,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] rdData,
    input  logic            rdWe,
    output logic [xlen-1:0] rs1Data,
    output logic [xlen-1:0] rs2Data
);

    // x1..x31 only, x0 is not stored
    logic [xlen-1:0] regs [31:1];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWe && rd != 5'd0) begin
            regs[rd] <= rdData; // Writes to x0 dropped
        end
    end

    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== hdl/singleCpu.sv ====
`timescale 1ns/10ps

module singleCpu
    import cpuPkg::*;
#(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic            CLK,
    input  logic            RST,
    input  logic            run,
    input  logic            progWe,
    input  logic [xlen-1:0] progAddr,
    input  logic [xlen-1:0] progData,
    output logic            retireValid,
    output retireT          retire
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] nextPc;
    logic [xlen-1:0] inst;
    ctrlT            ctrl;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluResult;
    logic            aluZero;
    logic [xlen-1:0] memRdData;
    logic [xlen-1:0] wbData;
    logic            commit;
    logic            rdWe;

    assign commit = run & ~RST; // One instruction per edge while set

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (commit) begin
            pc <= nextPc;
        end
    end

    // Taken beq goes to pc+imm
    assign nextPc = (ctrl.branch && aluZero) ? pc + ctrl.imm : pc + 32'd4;

    instMem #(.imemWords(imemWords)) u_instMem (
        .CLK      (CLK),
        .progWe   (progWe & ~run), // Loads only while halted
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .inst     (inst)
    );

    instDecode u_instDecode (
        .inst (inst),
        .ctrl (ctrl)
    );

    regFile u_regFile (
        .CLK     (CLK),
        .RST     (RST),
        .rs1     (ctrl.rs1),
        .rs2     (ctrl.rs2),
        .rd      (ctrl.rd),
        .rdData  (wbData),
        .rdWe    (ctrl.regWrite & commit),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    assign aluB = ctrl.aluSrc ? ctrl.imm : rs2Data;

    alu u_alu (
        .a      (rs1Data),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .zero   (aluZero)
    );

    dataMem #(.dmemWords(dmemWords)) u_dataMem (
        .CLK    (CLK),
        .addr   (aluResult),
        .wrData (rs2Data),
        .we     (ctrl.memWrite & commit),
        .rdData (memRdData)
    );

    assign wbData = ctrl.memToReg ? memRdData : aluResult;

    // x0 targets are not reported as writes
    assign rdWe = ctrl.regWrite && (ctrl.rd != 5'd0);

    // Retire record of the instruction at pc, unused fields zeroed
    always_comb begin
        retire.pc      = pc;
        retire.inst    = inst;
        retire.rdWe    = rdWe;
        retire.rd      = rdWe ? ctrl.rd : 5'd0;
        retire.rdData  = rdWe ? wbData : '0;
        retire.memWe   = ctrl.memWrite;
        retire.memAddr = ctrl.memWrite ? aluResult : '0;
        retire.memData = ctrl.memWrite ? rs2Data : '0;
    end

    assign retireValid = commit;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the single-cycle CPU testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module tbSingleCpu \
    -f singleCpu.f \
    --Mdir obj_dir -o simSingleCpu

./obj_dir/simSingleCpu > sim.log 2>&1
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
exit 0

// ==== singleCpu.f ====
common/cpuPkg.sv
hdl/instMem.sv
hdl/regFile.sv
hdl/dataMem.sv
decode/instDecode.sv
hdl/alu.sv
hdl/singleCpu.sv
dv/retireChecker.sv
dv/tbSingleCpu.sv
